/* logic/mips_pkg.sv */
package mips_pkg;

    // data and register values
    typedef logic [31:0] word_t;

    // byte addresses for the pc and the data bus
    typedef logic [31:0] addr_t;

    // raw instruction word as read from the boot ROM
    typedef logic [31:0] instr_t;

    // register number as found in the rs, rt and rd fields
    typedef logic [4:0] reg_idx_t;

    // major opcode, bits 31:26
    typedef logic [5:0] opcode_t;

    // function field of special instructions, bits 5:0
    typedef logic [5:0] funct_t;

    // first fetch after reset
    localparam addr_t RESET_VECTOR = 32'hBFC00000;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_SW      = 6'b101011;

    // special function codes
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_ADDU = 6'b100001;

    // v0, exported for observation
    localparam reg_idx_t REG_V0 = 5'd2;

    // execute sequencing
    // ST_RUN retires register-only instructions in one cycle
    // ST_MEM waits for the data bus to finish a load or store
    // ST_HALT is held after a run ends until reset
    typedef enum logic [1:0] {
        ST_RUN,
        ST_MEM,
        ST_HALT
    } exec_state_t;

endpackage

/* logic/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom
    import mips_pkg::*;
(
    input  addr_t  pc,
    output instr_t instr
);

    // fields the program words are built from
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    funct_t      funct;
    logic [15:0] imm;
    logic        r_type;

    always_comb begin
        opcode = OP_SPECIAL;
        rs     = '0;
        rt     = '0;
        rd     = '0;
        funct  = '0;
        imm    = '0;
        r_type = 1'b1;
        case (pc)
            32'hBFC00000: begin
                // lw r2, 0(r0)
                opcode = OP_LW;
                rt     = 5'd2;
                imm    = 16'h0000;
                r_type = 1'b0;
            end
            32'hBFC00004: begin
                // lw r3, 4(r0)
                opcode = OP_LW;
                rt     = 5'd3;
                imm    = 16'h0004;
                r_type = 1'b0;
            end
            32'hBFC00008: begin
                // beq r2, r3 to BFC0001C
                opcode = OP_BEQ;
                rs     = 5'd2;
                rt     = 5'd3;
                imm    = 16'h0004;
                r_type = 1'b0;
            end
            32'hBFC0000C: begin
                // addu r4, r2, r3 in the delay slot
                rs    = 5'd2;
                rt    = 5'd3;
                rd    = 5'd4;
                funct = FN_ADDU;
            end
            32'hBFC00010: begin
                // sw r4, 8(r0)
                opcode = OP_SW;
                rt     = 5'd4;
                imm    = 16'h0008;
                r_type = 1'b0;
            end
            32'hBFC0001C: begin
                // sw r2, 12(r0)
                opcode = OP_SW;
                rt     = 5'd2;
                imm    = 16'h000C;
                r_type = 1'b0;
            end
            32'hBFC00014, 32'hBFC00020: begin
                // jr r0, run ends after the next slot
                funct = FN_JR;
            end
            // everything else reads as a nop
            default: ;
        endcase
        if (r_type) begin
            // shift amount is unused by this program
            instr = {opcode, rs, rt, rd, 5'd0, funct};
        end else begin
            instr = {opcode, rs, rt, imm};
        end
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_target,
    output addr_t pc,
    output logic  halted
);

    // address that follows the instruction now in execute
    addr_t next_pc;
    logic  halted_q;
    logic  retire;

    // reaching address zero ends the run in the same cycle
    assign halted = halted_q || (pc == '0);

    assign retire = !stall && !halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= RESET_VECTOR;
            next_pc <= RESET_VECTOR + 32'd4;
        end else if (retire) begin
            // the delay slot is always next_pc
            pc <= next_pc;
            if (redirect) begin
                next_pc <= redirect_target;
            end else begin
                next_pc <= next_pc + 32'd4;
            end
        end
    end

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            halted_q <= 1'b0;
        end else if (pc == '0) begin
            halted_q <= 1'b1;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    word_t regs [32];

    // r0 is cleared by reset and never written, so it reads as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    assign v0 = regs[REG_V0];

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     halted,
    input  logic     mem_done,
    input  instr_t   instr,
    input  addr_t    pc,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  word_t    mem_rdata,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output reg_idx_t wr_idx,
    output logic     wr_en,
    output word_t    wr_data,
    output logic     stall,
    output logic     redirect,
    output logic     mem_req,
    output logic     mem_write,
    output addr_t    redirect_target,
    output addr_t    mem_addr,
    output word_t    mem_wdata,
    output logic     active
);

    exec_state_t state;
    exec_state_t state_next;

    // instruction fields
    opcode_t     opcode;
    funct_t      funct;
    reg_idx_t    rd;
    logic [15:0] imm;
    word_t       imm_sext;

    logic  is_lw;
    logic  is_sw;
    logic  is_mem;
    logic  is_beq;
    logic  is_jr;
    logic  is_addu;
    logic  run_ok;
    logic  load_done;
    addr_t branch_target;

    assign opcode   = instr[31:26];
    assign rs_idx   = instr[25:21];
    assign rt_idx   = instr[20:16];
    assign rd       = instr[15:11];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};

    assign is_lw   = (opcode == OP_LW);
    assign is_sw   = (opcode == OP_SW);
    assign is_mem  = is_lw || is_sw;
    assign is_beq  = (opcode == OP_BEQ);
    assign is_jr   = (opcode == OP_SPECIAL) && (funct == FN_JR);
    assign is_addu = (opcode == OP_SPECIAL) && (funct == FN_ADDU);

    // ready to retire or start something this cycle
    assign run_ok = (state == ST_RUN) && !halted;

    // load and store address is base plus signed offset
    assign mem_addr  = rs_data + imm_sext;
    assign mem_wdata = rt_data;
    assign mem_write = is_sw;
    assign mem_req   = (run_ok && is_mem) || (state == ST_MEM);

    // beq offset counts words from the delay slot
    assign branch_target   = pc + 32'd4 + (imm_sext << 2);
    assign redirect_target = is_jr ? rs_data : branch_target;
    assign redirect        = run_ok && (is_jr || (is_beq && (rs_data == rt_data)));

    // fetch only moves when an instruction retires
    assign stall = !((run_ok && !is_mem) || (state == ST_MEM && mem_done));

    assign load_done = (state == ST_MEM) && mem_done && !mem_write;

    // one write port shared by addu and load return
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = rd;
        wr_data = rs_data + rt_data;
        if (load_done) begin
            wr_en   = 1'b1;
            wr_idx  = rt_idx;
            wr_data = mem_rdata;
        end else if (run_ok && is_addu) begin
            wr_en = 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_RUN: begin
                if (halted) begin
                    state_next = ST_HALT;
                end else if (is_mem) begin
                    state_next = ST_MEM;
                end
            end
            ST_MEM: begin
                if (mem_done) begin
                    state_next = ST_RUN;
                end
            end
            ST_HALT: begin
                // held until reset
                state_next = ST_HALT;
            end
            default: state_next = ST_HALT;
        endcase
    end

    // reset leaves the first instruction ready to run
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    assign active = !rst && (state != ST_HALT) && !halted;

endmodule

/* logic/apb_data_master.sv */
`timescale 1ns/1ps

module apb_data_master
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_req,
    input  logic  mem_write,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    input  word_t prdata,
    input  logic  pready,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    output addr_t paddr,
    output word_t pwdata,
    output logic  mem_done,
    output word_t mem_rdata
);

    logic idle;
    logic start;

    // psel and penable together encode idle, setup and access
    assign idle  = !psel;
    assign start = idle && mem_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            psel    <= 1'b0;
            penable <= 1'b0;
        end else if (start) begin
            psel <= 1'b1;
        end else if (psel && !penable) begin
            penable <= 1'b1;
        end else if (psel && pready) begin
            // back to idle, request drops in the same cycle
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    end

    // held from setup to the end of access
    always_ff @(posedge clk) begin
        if (start) begin
            pwrite <= mem_write;
            paddr  <= mem_addr;
            pwdata <= mem_wdata;
        end
    end

    // single pulse in the pready cycle
    assign mem_done = psel && penable && pready;

    // slave data is only valid with mem_done
    assign mem_rdata = prdata;

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t prdata,
    input  logic  pready,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    output addr_t paddr,
    output word_t pwdata,
    output logic  active,
    output word_t register_v0
);

    // fetch and ROM
    addr_t  pc;
    instr_t instr;
    logic   halted;

    // execute to fetch
    logic  stall;
    logic  redirect;
    addr_t redirect_target;

    // register file
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t wr_idx;
    logic     wr_en;
    word_t    wr_data;
    word_t    rs_data;
    word_t    rt_data;

    // execute to data master
    logic  mem_req;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_done;
    word_t mem_rdata;

    fetch_unit u_fetch (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (pc),
        .halted          (halted)
    );

    boot_rom u_rom (
        .pc    (pc),
        .instr (instr)
    );

    exec_unit u_exec (
        .clk             (clk),
        .rst             (rst),
        .halted          (halted),
        .mem_done        (mem_done),
        .instr           (instr),
        .pc              (pc),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .mem_rdata       (mem_rdata),
        .rs_idx          (rs_idx),
        .rt_idx          (rt_idx),
        .wr_idx          (wr_idx),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .stall           (stall),
        .redirect        (redirect),
        .mem_req         (mem_req),
        .mem_write       (mem_write),
        .redirect_target (redirect_target),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .active          (active)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    apb_data_master u_apb (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .prdata    (prdata),
        .pready    (pready),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

endmodule

/* tests/mips_core_checker.sv */
`timescale 1ns/1ps

module mips_core_checker
    import mips_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  psel,
    input logic  penable,
    input logic  pready,
    input logic  pwrite,
    input addr_t paddr,
    input word_t pwdata,
    input logic  active
);

    // count of failed assertions
    int unsigned error_count = 0;

    setup_then_access: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> psel && penable)
    else begin
        $error("APB setup cycle not followed by access");
        error_count++;
    end

    // request fields hold until pready ends the transfer
    request_stable: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else begin
        $error("APB request changed before pready");
        error_count++;
    end

    // active is high from the first cycle out of reset, so any low is final
    halt_sticky: assert property (@(posedge clk) disable iff (rst)
        !active |=> !active)
    else begin
        $error("active rose again after halt");
        error_count++;
    end

    no_bus_when_idle: assert property (@(posedge clk) disable iff (rst)
        !active |-> !psel)
    else begin
        $error("psel high while the core is not active");
        error_count++;
    end

endmodule

bind mips_core mips_core_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .active  (active)
);

/* tests/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb
    import mips_pkg::*;
();

    // 5 tests of about 80 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_CYCLES   = 5;
    localparam int HALT_WATCH     = 20;

    logic  clk = 1'b0;
    logic  rst;
    word_t prdata;
    logic  pready;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    logic  active;
    word_t register_v0;

    // data memory words and slave state
    word_t       mem0;
    word_t       mem4;
    logic        use_waits;
    logic        in_access;
    int unsigned wait_left;
    logic [31:0] lfsr_state = 32'h695917bf;
    int unsigned cycle_count = 0;

    // transfers seen by the slave since the last reset
    addr_t read_log [$];
    addr_t write_addr_log [$];
    word_t write_data_log [$];

    always #50 clk = ~clk;

    mips_core DUT (
        .clk         (clk),
        .rst         (rst),
        .prdata      (prdata),
        .pready      (pready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .active      (active),
        .register_v0 (register_v0)
    );

    // galois form, x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    // three bits, one lfsr step each
    task automatic draw_wait(output int unsigned w);
        w = 0;
        for (int i = 0; i < 3; i++) begin
            w = (w << 1) | lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic word_t read_word(input addr_t a);
        case (a)
            32'h0000_0000: return mem0;
            32'h0000_0004: return mem4;
            default: return ~a;
        endcase
    endfunction

    // APB slave, answers 1 ns after each rising edge
    always @(posedge clk) begin
        #1;
        if (psel && penable) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = 0;
                if (use_waits) begin
                    draw_wait(wait_left);
                end
            end
            if (wait_left != 0) begin
                pready = 1'b0;
                wait_left--;
            end else begin
                pready = 1'b1;
                if (pwrite) begin
                    write_addr_log.push_back(paddr);
                    write_data_log.push_back(pwdata);
                end else begin
                    read_log.push_back(paddr);
                    prdata = read_word(paddr);
                end
            end
        end else begin
            in_access = 1'b0;
            pready    = 1'b0;
        end
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout: no finish within %0d cycles", TIMEOUT_CYCLES));
        end
        if (DUT.u_checker.error_count != 0) begin
            stop_with_failure("An APB or halt assertion failed");
        end
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d",
                                        name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_core(input word_t m0, input word_t m4, input logic waits);
        rst = 1'b1;
        next_cycle();
        check_flag("reset psel", 1'b0, psel);
        check_flag("reset active", 1'b0, active);
        // bus is idle now, slave state may change
        mem0      = m0;
        mem4      = m4;
        use_waits = waits;
        read_log.delete();
        write_addr_log.delete();
        write_data_log.delete();
        repeat (RESET_CYCLES - 1) begin
            next_cycle();
        end
        rst = 1'b0;
        // core runs from the reset vector in this very cycle
        #1;
        check_flag("reset release active", 1'b1, active);
    endtask

    task automatic run_to_halt();
        while (active === 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic check_results(input string name, input word_t m0, input word_t m4);
        addr_t exp_addr;
        word_t exp_data;
        // taken beq skips sw r4 and stores r2 at 12
        if (m0 == m4) begin
            exp_addr = 32'd12;
            exp_data = m0;
        end else begin
            exp_addr = 32'd8;
            exp_data = m0 + m4;
        end
        check_count({name, " reads"}, 2, read_log.size());
        check_addr({name, " first read"}, 32'd0, read_log[0]);
        check_addr({name, " second read"}, 32'd4, read_log[1]);
        check_count({name, " writes"}, 1, write_addr_log.size());
        check_addr({name, " write address"}, exp_addr, write_addr_log[0]);
        check_word({name, " write data"}, exp_data, write_data_log[0]);
        check_word({name, " v0"}, m0, register_v0);
        check_flag({name, " active"}, 1'b0, active);
    endtask

    task automatic test_taken_branch(input logic waits);
        string name;
        name = waits ? "taken_branch_waits" : "taken_branch";
        reset_core(32'h1234_5678, 32'h1234_5678, waits);
        run_to_halt();
        check_results(name, 32'h1234_5678, 32'h1234_5678);
    endtask

    task automatic test_not_taken(input logic waits);
        string name;
        name = waits ? "not_taken_waits" : "not_taken";
        // sum wraps past 32 bits
        reset_core(32'hFFFF_FFF0, 32'h0000_0025, waits);
        run_to_halt();
        check_results(name, 32'hFFFF_FFF0, 32'h0000_0025);
    endtask

    task automatic test_back_pressure();
        test_taken_branch(1'b1);
        test_not_taken(1'b1);
    endtask

    task automatic test_halt();
        reset_core(32'hCAFE_0001, 32'h0000_7FFF, 1'b0);
        run_to_halt();
        repeat (HALT_WATCH) begin
            next_cycle();
            check_flag("halt active", 1'b0, active);
            check_flag("halt psel", 1'b0, psel);
        end
        check_count("halt reads", 2, read_log.size());
        check_count("halt writes", 1, write_addr_log.size());
    endtask

    task automatic test_reset_mid_run();
        reset_core(32'h0BAD_0BAD, 32'h0BAD_0BAD, 1'b1);
        // first load in its access phase
        while (!(psel && penable)) begin
            next_cycle();
        end
        reset_core(32'h8000_0000, 32'h8000_0001, 1'b1);
        run_to_halt();
        check_results("reset_mid_run", 32'h8000_0000, 32'h8000_0001);
    endtask

    initial begin
        rst       = 1'b1;
        prdata    = '0;
        pready    = 1'b0;
        use_waits = 1'b0;
        in_access = 1'b0;
        wait_left = 0;
        mem0      = '0;
        mem4      = '0;
        test_taken_branch(1'b0);
        test_not_taken(1'b0);
        test_back_pressure();
        test_halt();
        test_reset_mid_run();
        if (DUT.u_checker.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("An APB or halt assertion failed");
        end
    end

endmodule

/* verilog.f */
logic/mips_pkg.sv
logic/boot_rom.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/apb_data_master.sv
logic/mips_core.sv
tests/mips_core_checker.sv
tests/mips_core_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - logic/mips_pkg.sv
      - logic/boot_rom.sv
      - logic/fetch_unit.sv
      - logic/reg_file.sv
      - logic/exec_unit.sv
      - logic/apb_data_master.sv
      - logic/mips_core.sv
  - target: test
    files:
      - tests/mips_core_checker.sv
      - tests/mips_core_tb.sv
